// File: logic/iic_pkg.sv
package iic_pkg;

	// latched bus condition from the detector
	typedef enum logic [1:0] {
		SS_NONE,
		SS_START,
		SS_STOP
	} ss_event_t;

	// byte-level target FSM
	typedef enum logic [3:0] {
		ST_START_CONDITION,
		ST_IN_ADDRESS,
		ST_CHECK_ADDRESS,
		ST_IN_DATA,
		ST_CHECK_IN_DATA,
		ST_OUT_DATA,
		ST_CHECK_OUT_DATA,
		ST_DATA_LOOP,
		ST_ACK
	} ctrl_state_t;

	// what the current byte stream carries
	typedef enum logic [1:0] {
		STREAM_NULL,
		STREAM_ADDRESS,
		STREAM_WRITE,
		STREAM_READ
	} stream_t;

	// SDA levels in the ninth bit slot
	localparam logic I2C_ACK = 1'b0;
	localparam logic I2C_NACK = 1'b1;

endpackage

// File: logic/iic_line_if.sv
`timescale 1ns/1ps

interface iic_line_if;
	logic scl;        // filtered
	logic sda;        // filtered, resolved bus level
	logic sda_out_en; // target pulls SDA when high
	logic sda_out;

	modport filter (
		output scl,
		output sda
	);

	modport det (
		input scl,
		input sda
	);

	modport ctrl (
		input scl,
		input sda,
		output sda_out_en,
		output sda_out
	);
endinterface

// File: logic/iic_line_filter.sv
`timescale 1ns/1ps

module iic_line_filter #(
	parameter int FILTER_LEN = 3
) (
	input logic clk,
	input logic rst_n,
	input logic scl_in,
	input logic sda_in,
	iic_line_if.filter line
);
	localparam int CW = $clog2(FILTER_LEN + 1);

	// bit 1 is scl, bit 0 is sda
	logic [1:0] sync1;
	logic [1:0] sync2;
	logic [1:0] filt;
	logic [CW-1:0] cnt [2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync1 <= 2'b11;
			sync2 <= 2'b11;
			filt <= 2'b11; // idle bus is high
			for (int i = 0; i < 2; i++)
				cnt[i] <= '0;
		end else begin
			sync1 <= {scl_in, sda_in};
			sync2 <= sync1;
			for (int i = 0; i < 2; i++) begin
				if (sync2[i] == filt[i]) begin
					cnt[i] <= '0; // glitch gone, start over
				end else if (cnt[i] == CW'(FILTER_LEN - 1)) begin
					filt[i] <= sync2[i];
					cnt[i] <= '0;
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

	assign line.scl = filt[1];
	assign line.sda = filt[0];
endmodule

// File: logic/iic_start_stop_det.sv
`timescale 1ns/1ps

module iic_start_stop_det
	import iic_pkg::*;
(
	input logic clk,
	input logic rst_n,
	iic_line_if.det line,
	input logic det_enable,
	output ss_event_t ss_event
);
	logic sda_d;
	logic start_edge;
	logic stop_edge;

	// SDA may only move while SCL is high for a bus condition
	assign start_edge = line.scl && sda_d && !line.sda;
	assign stop_edge = line.scl && !sda_d && line.sda;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sda_d <= 1'b1;
			ss_event <= SS_NONE;
		end else begin
			sda_d <= line.sda;
			if (!det_enable) begin
				ss_event <= SS_NONE; // controller acknowledged
			end else if (ss_event == SS_NONE) begin
				if (start_edge) begin
					ss_event <= SS_START;
				end else if (stop_edge) begin
					ss_event <= SS_STOP;
				end
			end
		end
	end

	// a bus condition is one sda edge under a steady high scl
	assert property (@(posedge clk) disable iff (!rst_n)
		(start_edge || stop_edge) |-> $stable(line.scl))
		else $error("bus condition seen while SCL was moving");
endmodule

// File: logic/iic_slave_interface.sv
`timescale 1ns/1ps

module iic_slave_interface
	import iic_pkg::*;
#(
	parameter logic [6:0] I2C_ADDRESS = 7'h3c
) (
	input logic clk,
	input logic rst_n,
	iic_line_if.ctrl line,
	input ss_event_t ss_event,
	output logic det_enable,
	output logic rx_wen,
	output logic [7:0] rx_wdata,
	output logic tx_ren,
	input logic [7:0] tx_rdata
);
	ctrl_state_t state;
	stream_t stream;
	logic [2:0] bit_cnt;
	logic [7:0] tx_shift;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			det_enable <= 1'b1;
			line.sda_out_en <= 1'b0;
			line.sda_out <= I2C_NACK; // released level
			rx_wen <= 1'b0;
			rx_wdata <= '0;
			tx_ren <= 1'b0;
			tx_shift <= '0;
			stream <= STREAM_NULL;
			bit_cnt <= '0;
			state <= ST_START_CONDITION;
		end else begin
			rx_wen <= 1'b0;
			tx_ren <= 1'b0;

			if (ss_event != SS_NONE) begin
				// START, repeated START or STOP restarts the frame
				det_enable <= 1'b0;
				line.sda_out_en <= 1'b0;
				stream <= STREAM_NULL;
				state <= ST_START_CONDITION;
			end else begin
				case (state)
					ST_START_CONDITION: begin
						det_enable <= 1'b1;
						bit_cnt <= '0;
						state <= ST_IN_ADDRESS;
					end
					ST_IN_ADDRESS: begin
						if (!line.scl) begin
							line.sda_out_en <= 1'b0;
							stream <= STREAM_ADDRESS;
							state <= ST_DATA_LOOP;
						end
					end
					ST_CHECK_ADDRESS: begin
						if (!line.scl) begin
							if (rx_wdata[7:1] == I2C_ADDRESS) begin
								stream <= rx_wdata[0] ? STREAM_READ : STREAM_WRITE;
								line.sda_out <= I2C_ACK;
								line.sda_out_en <= 1'b1;
								state <= ST_ACK;
							end else begin
								stream <= STREAM_NULL; // not addressed so stay off the bus
							end
						end
					end
					ST_IN_DATA: begin
						if (!line.scl) begin
							line.sda_out_en <= 1'b0; // end of ack
							state <= ST_DATA_LOOP;
						end
					end
					ST_CHECK_IN_DATA: begin
						if (!line.scl) begin
							line.sda_out <= I2C_ACK;
							line.sda_out_en <= 1'b1;
							state <= ST_ACK;
						end
					end
					ST_OUT_DATA: begin
						if (!line.scl) begin
							line.sda_out <= tx_shift[7]; // msb first
							line.sda_out_en <= 1'b1;
							tx_shift <= {tx_shift[6:0], 1'b0};
							state <= ST_DATA_LOOP;
						end
					end
					ST_CHECK_OUT_DATA: begin
						if (!line.scl) begin
							line.sda_out_en <= 1'b0; // let master ack
							state <= ST_ACK;
						end
					end
					ST_DATA_LOOP: begin
						if (line.scl) begin
							case (stream)
								STREAM_ADDRESS: begin
									rx_wdata <= {rx_wdata[6:0], line.sda};
									if (bit_cnt == 3'd7) begin
										state <= ST_CHECK_ADDRESS;
									end else begin
										state <= ST_IN_ADDRESS;
									end
								end
								STREAM_WRITE: begin
									rx_wdata <= {rx_wdata[6:0], line.sda};
									if (bit_cnt == 3'd7) begin
										rx_wen <= 1'b1;
										state <= ST_CHECK_IN_DATA;
									end else begin
										state <= ST_IN_DATA;
									end
								end
								STREAM_READ: begin
									if (bit_cnt == 3'd7) begin
										state <= ST_CHECK_OUT_DATA;
									end else begin
										state <= ST_OUT_DATA;
									end
								end
								default: begin
								end
							endcase
							bit_cnt <= bit_cnt + 3'd1; // wraps after 8 bits
						end
					end
					ST_ACK: begin
						if (line.scl) begin
							case (stream)
								STREAM_WRITE: begin
									state <= ST_IN_DATA;
								end
								STREAM_READ: begin
									// own address ack or master ack
									if (line.sda_out_en || line.sda == I2C_ACK) begin
										tx_shift <= tx_rdata;
										tx_ren <= 1'b1;
										state <= ST_OUT_DATA;
									end else begin
										stream <= STREAM_NULL; // master nack ends the stream
									end
								end
								default: begin
								end
							endcase
						end
					end
					default: begin
						state <= ST_START_CONDITION;
					end
				endcase
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) !(rx_wen && tx_ren))
		else $error("rx_wen and tx_ren high together");

	// no stream open means the target never holds SDA
	assert property (@(posedge clk) disable iff (!rst_n)
		(stream == STREAM_NULL) |-> !line.sda_out_en)
		else $error("SDA driven with no open stream");
endmodule

// File: logic/iic_byte_fifo.sv
`timescale 1ns/1ps

module iic_byte_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input logic clk,
	input logic rst_n,
	input logic wen,
	input logic [7:0] wdata,
	input logic ren,
	output logic [7:0] rdata,
	output logic full,
	output logic empty
);
	localparam int AW = $clog2(FIFO_DEPTH);

	logic [7:0] mem [FIFO_DEPTH];
	logic [AW:0] wptr; // msb is the wrap bit
	logic [AW:0] rptr;
	logic do_write;
	logic do_read;

	assign do_write = wen && !full;
	assign do_read = ren && !empty;
	assign empty = (wptr == rptr);
	assign full = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);
	assign rdata = empty ? 8'hff : mem[rptr[AW-1:0]]; // show-ahead head

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wptr[AW-1:0]] <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (do_write) begin
				wptr <= wptr + 1'b1;
			end
			if (do_read) begin
				rptr <= rptr + 1'b1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) !(wen && full))
		else $warning("byte dropped, fifo full");

	assert property (@(posedge clk) disable iff (!rst_n) !(ren && empty))
		else $warning("read from empty fifo ignored");
endmodule

// File: logic/iic_slave_top.sv
`timescale 1ns/1ps

module iic_slave_top
	import iic_pkg::*;
#(
	parameter logic [6:0] I2C_ADDRESS = 7'h3c,
	parameter int FIFO_DEPTH = 8,
	parameter int FILTER_LEN = 3
) (
	input logic clk,
	input logic rst_n,
	input logic scl_in,
	input logic sda_in,
	output logic sda_out_en,
	output logic sda_out,
	output logic rx_valid,
	input logic rx_ready,
	output logic [7:0] rx_data,
	input logic tx_valid,
	output logic tx_ready,
	input logic [7:0] tx_data
);
	iic_line_if line ();

	ss_event_t ss_event;
	logic det_enable;
	logic rx_wen;
	logic [7:0] rx_wdata;
	logic tx_ren;
	logic [7:0] tx_rdata;
	logic rx_empty;
	logic rx_pop;
	logic tx_full;
	logic tx_push;

	assign sda_out_en = line.sda_out_en;
	assign sda_out = line.sda_out;
	assign rx_valid = !rx_empty;
	assign rx_pop = rx_valid && rx_ready;
	assign tx_ready = !tx_full;
	assign tx_push = tx_valid && tx_ready;

	iic_line_filter #(
		.FILTER_LEN(FILTER_LEN)
	) u_filter (
		.clk(clk),
		.rst_n(rst_n),
		.scl_in(scl_in),
		.sda_in(sda_in),
		.line(line.filter)
	);

	iic_start_stop_det u_det (
		.clk(clk),
		.rst_n(rst_n),
		.line(line.det),
		.det_enable(det_enable),
		.ss_event(ss_event)
	);

	iic_slave_interface #(
		.I2C_ADDRESS(I2C_ADDRESS)
	) u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.line(line.ctrl),
		.ss_event(ss_event),
		.det_enable(det_enable),
		.rx_wen(rx_wen),
		.rx_wdata(rx_wdata),
		.tx_ren(tx_ren),
		.tx_rdata(tx_rdata)
	);

	iic_byte_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_rx_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wen(rx_wen),
		.wdata(rx_wdata),
		.ren(rx_pop),
		.rdata(rx_data),
		.full(),
		.empty(rx_empty)
	);

	iic_byte_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_tx_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wen(tx_push),
		.wdata(tx_data),
		.ren(tx_ren),
		.rdata(tx_rdata),
		.full(tx_full),
		.empty()
	);
endmodule

// File: sim/iic_slave_tb.sv
`timescale 1ns/1ps

module iic_slave_tb
	import iic_pkg::*;
();
	localparam logic [6:0] DUT_ADDR = 7'h3c;
	localparam int COLS = 13; // kind addr dir count d0..d7 ack
	localparam int VEC_MAX = 32;
	localparam int QUARTER = 8; // clocks per scl quarter period
	localparam int unsigned SEED = 32'h7243d214;

	logic clk;
	logic rst_n;
	logic scl_m;
	logic sda_m; // master side of the open-drain line
	logic sda_in;
	logic sda_out_en;
	logic sda_out;
	logic rx_valid;
	logic rx_ready;
	logic [7:0] rx_data;
	logic tx_valid;
	logic tx_ready;
	logic [7:0] tx_data;

	logic [7:0] vec [VEC_MAX*COLS];
	logic [7:0] rx_expect [$];
	int nvec;
	int wd_cycles;
	int n_checks;
	int n_errors;

	assign sda_in = sda_m & ~(sda_out_en & ~sda_out); // wired-and

	iic_slave_top #(
		.I2C_ADDRESS(DUT_ADDR),
		.FIFO_DEPTH(8),
		.FILTER_LEN(3)
	) i_iic_slave_top (
		.clk(clk),
		.rst_n(rst_n),
		.scl_in(scl_m),
		.sda_in(sda_in),
		.sda_out_en(sda_out_en),
		.sda_out(sda_out),
		.rx_valid(rx_valid),
		.rx_ready(rx_ready),
		.rx_data(rx_data),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.tx_data(tx_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("FAILED at %0t: %s expected %02h, got %02h", $time, name, exp, act);
		end
	endtask

	task automatic check_ack(input string name, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("FAILED at %0t: %s expected %0b, got %0b", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("FAILED at %0t: %s expected %0b, got %0b", $time, name, exp, act);
		end
	endtask

	task automatic wait_quarter();
		repeat (QUARTER) @(posedge clk);
		#1;
	endtask

	task automatic send_start();
		wait_quarter();
		sda_m = 1'b1;
		wait_quarter();
		scl_m = 1'b1;
		wait_quarter();
		sda_m = 1'b0; // falls while scl high
		wait_quarter();
		scl_m = 1'b0;
	endtask

	task automatic send_stop();
		wait_quarter();
		sda_m = 1'b0;
		wait_quarter();
		scl_m = 1'b1;
		wait_quarter();
		sda_m = 1'b1; // rises while scl high
		wait_quarter();
	endtask

	// one scl period with the sample taken mid scl high
	task automatic clock_bit(input logic b, output logic sampled);
		wait_quarter();
		sda_m = b;
		wait_quarter();
		scl_m = 1'b1;
		wait_quarter();
		sampled = sda_in;
		wait_quarter();
		scl_m = 1'b0;
	endtask

	task automatic send_byte(input logic [7:0] data, output logic ack);
		logic s;
		for (int i = 7; i >= 0; i--)
			clock_bit(data[i], s);
		clock_bit(1'b1, ack); // released for target ack
	endtask

	task automatic receive_byte(input logic master_ack, output logic [7:0] data);
		logic s;
		for (int i = 7; i >= 0; i--) begin
			clock_bit(1'b1, s);
			data[i] = s;
		end
		clock_bit(master_ack, s);
	endtask

	task automatic preload_tx(input int base);
		int waited;
		for (int j = 0; j < int'(vec[base + 3]); j++) begin
			tx_valid = 1'b1;
			tx_data = vec[base + 4 + j];
			waited = 0;
			while (!tx_ready && waited < 100) begin
				@(posedge clk);
				#1;
				waited++;
			end
			if (!tx_ready) begin
				n_errors++;
				$display("tx queue stayed full while loading byte %0d", j);
			end
			@(posedge clk);
			#1;
		end
		tx_valid = 1'b0;
	endtask

	task automatic drain_rx();
		logic [7:0] exp;
		int gap;
		int waited;
		while (rx_expect.size() > 0) begin
			exp = rx_expect.pop_front();
			gap = $urandom_range(0, 3);
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
			rx_ready = 1'b1;
			waited = 0;
			while (!rx_valid && waited < 100) begin
				@(posedge clk);
				#1;
				waited++;
			end
			if (!rx_valid) begin
				n_errors++;
				$display("received byte %02h never showed up on the host side", exp);
			end else begin
				check_byte("rx_data", exp, rx_data);
			end
			@(posedge clk); // pop
			#1;
			rx_ready = 1'b0;
		end
	endtask

	task automatic run_transaction(input int base);
		logic [7:0] data;
		logic [7:0] got;
		logic exp_ack;
		logic ack;
		logic dir;
		int cnt;
		cnt = int'(vec[base + 3]);
		dir = vec[base + 2][0];
		exp_ack = vec[base + 12][0];
		send_start();
		send_byte({vec[base + 1][6:0], dir}, ack);
		check_ack("address ack", exp_ack, ack);
		if (exp_ack == I2C_ACK) begin
			for (int j = 0; j < cnt; j++) begin
				data = vec[base + 4 + j];
				if (dir == 1'b0) begin
					send_byte(data, ack);
					check_ack("data ack", I2C_ACK, ack);
					rx_expect.push_back(data);
				end else begin
					receive_byte((j == cnt - 1) ? I2C_NACK : I2C_ACK, got);
					check_byte("read data", data, got);
				end
			end
			if (dir == 1'b1) begin
				wait_quarter();
				wait_quarter();
				check_flag("sda_out_en", 1'b0, sda_out_en); // off the bus after nack
			end
		end
		if (vec[base] == 8'h01) begin
			send_stop();
			drain_rx();
			check_flag("rx_valid", 1'b0, rx_valid);
		end
	endtask

	initial begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		scl_m = 1'b1;
		sda_m = 1'b1;
		rx_ready = 1'b0;
		tx_valid = 1'b0;
		tx_data = 8'h00;
		$readmemh("sim/iic_vectors.txt", vec);
		nvec = 0;
		while (nvec < VEC_MAX && vec[nvec*COLS] != 8'hff)
			nvec++;
		if (nvec == 0) begin
			n_errors++;
			$display("no transactions found in the vector file");
		end
		wd_cycles = nvec * 40 * 32 * 2;

		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		#1;
		check_flag("sda_out_en", 1'b0, sda_out_en);
		check_flag("rx_valid", 1'b0, rx_valid);
		check_flag("tx_ready", 1'b1, tx_ready);

		for (int v = 0; v < nvec; v++) begin
			case (vec[v*COLS])
				8'h00: preload_tx(v*COLS);
				8'h01, 8'h02: run_transaction(v*COLS);
				default: begin
					n_errors++;
					$display("unknown transaction kind %02h on vector %0d", vec[v*COLS], v);
				end
			endcase
		end

		repeat (10) @(posedge clk);
		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk);
		$display("timeout, run did not end within %0d clock cycles", wd_cycles);
		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		$display("** FAIL **");
		$finish;
	end
endmodule

// File: sim/iic_vectors.txt
// kind addr dir count d0 d1 d2 d3 d4 d5 d6 d7 ack, all hex
// kind 00 loads the tx queue, 01 runs START..STOP, 02 leaves the bus for a repeated START
01 3c 00 03 a5 5a 01 00 00 00 00 00 00
01 3c 00 08 00 ff 80 7f 12 34 56 78 00
01 3d 00 02 11 22 00 00 00 00 00 00 01
00 00 00 04 c3 3c 96 69 00 00 00 00 00
01 2a 01 01 00 00 00 00 00 00 00 00 01
01 3c 01 06 c3 3c 96 69 ff ff 00 00 00
00 00 00 02 de ad 00 00 00 00 00 00 00
02 3c 00 02 10 20 00 00 00 00 00 00 00
01 3c 01 03 de ad ff 00 00 00 00 00 00
01 3c 01 01 ff 00 00 00 00 00 00 00 00
01 3c 00 01 e7 00 00 00 00 00 00 00 00
// end marker
ff 00 00 00 00 00 00 00 00 00 00 00 00

// File: iic_slave.f
logic/iic_pkg.sv
logic/iic_line_if.sv
logic/iic_line_filter.sv
logic/iic_start_stop_det.sv
logic/iic_slave_interface.sv
logic/iic_byte_fifo.sv
logic/iic_slave_top.sv
sim/iic_slave_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --top-module iic_slave_tb -f iic_slave.f -o sim_iic \
	&& ./obj_dir/sim_iic | tee /dev/stderr | grep -qF '** PASS **' \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
